// File: dv/fetch_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
  input logic         clock,
  input logic         reset,
  input logic [31:0]  araddr,
  input logic         arvalid,
  input logic         arready,
  input logic         inst_valid,
  input logic         inst_ready,
  input logic [31:0]  inst,
  input logic [31:0]  inst_pc,
  input logic         inst_error
);

  // Address channel holds until the memory takes it
  ar_stable: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("araddr or arvalid changed before the address was accepted");

  // Stalled decode sees frozen outputs
  inst_stable: assert property (@(posedge clock) disable iff (reset)
    inst_valid && !inst_ready |=> $stable(inst) && $stable(inst_pc) && $stable(inst_error))
    else $error("decode outputs changed while stalled");

  ar_aligned: assert property (@(posedge clock) disable iff (reset)
    arvalid |-> araddr[2:0] == 3'b000)
    else $error("araddr is not a line base address");

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
  .clock      (clock),
  .reset      (reset),
  .araddr     (araddr),
  .arvalid    (arvalid),
  .arready    (arready),
  .inst_valid (inst_valid),
  .inst_ready (inst_ready),
  .inst       (inst),
  .inst_pc    (inst_pc),
  .inst_error (inst_error)
);

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb import mem_pkg::*; ();

  localparam int TARGET_COUNT = 3000;
  localparam int IDLE_LIMIT   = 2000;
  localparam int MAX_CYCLES   = 200000;
  localparam int TAG_LO       = `OFFSET_BITS + `INDEX_BITS;

  logic        clock;
  logic        reset;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        flush;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_error;
  logic        inst_ready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  resp_t       rresp;
  logic        rvalid;
  logic        rlast;
  logic        rready;

  integer seed;

  // Reference model of the expected pc and the cache tags
  logic [31:0]              exp_pc;
  logic [`LINE_COUNT-1:0]   shadow_valid;
  logic [`TAG_BITS-1:0]     shadow_tag [`LINE_COUNT];
  logic [`LINE_COUNT-1:0]   last_valid;
  logic [`TAG_BITS-1:0]     last_tag [`LINE_COUNT];
  int                       ar_count;
  logic [31:0]              ar_last;
  logic                     clean;
  int                       accepted;
  int                       cycle;
  int                       idle_cycles;
  int                       stall_left;

  // Memory model
  logic        burst_live;
  logic [31:0] burst_addr;
  logic        beat_high;
  int          ar_delay;
  logic        r_hold;

  // Values seen in the previous cycle
  logic        held_prev;
  logic [31:0] inst_prev;
  logic [31:0] pc_prev;
  logic        error_prev;
  logic        ar_wait_prev;
  logic [31:0] araddr_prev;

  fetch_top u_dut (.*);

  initial clock = 1'b0;
  always #20 clock = ~clock;

  // Fixed scramble of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    return (w * 32'h9e37_79b9) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  // Eight lines at 0x3000_0180 answer with SLVERR
  function automatic logic err_line(input logic [31:0] addr);
    return (addr >> 6) == 32'h00c0_0006;
  endfunction

  function automatic logic cacheable(input logic [31:0] addr);
    return addr[31:24] != `UNCACHED_TOP;
  endfunction

  function automatic logic last_hit(input logic [31:0] addr);
    return last_valid[addr[6:3]] && (last_tag[addr[6:3]] == addr[31:TAG_LO])
        && cacheable(addr);
  endfunction

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic drive_inputs();
    redirect = ($unsigned($random(seed)) % 20) == 0;
    if (redirect) begin
      if (($unsigned($random(seed)) % 5) == 0) begin
        redirect_pc = 32'h0f00_0000 | ($unsigned($random(seed)) & 32'h0000_007c);
      end else begin
        redirect_pc = `RESET_PC | ($unsigned($random(seed)) & 32'h0000_01fc);
      end
    end
    flush = ($unsigned($random(seed)) % 60) == 0;
    // Random decode stalls with an occasional long one
    if (stall_left > 0) begin
      stall_left = stall_left - 1;
      inst_ready = 1'b0;
    end else if (($unsigned($random(seed)) % 40) == 0) begin
      stall_left = 10 + int'($unsigned($random(seed)) % 30);
      inst_ready = 1'b0;
    end else begin
      inst_ready = ($unsigned($random(seed)) % 4) != 0;
    end
    // Address accepted after 0 to 3 wait cycles
    arready = 1'b0;
    if (arvalid && !burst_live) begin
      if (ar_delay < 0) begin
        ar_delay = int'($unsigned($random(seed)) % 4);
      end
      if (ar_delay == 0) begin
        arready = 1'b1;
      end else begin
        ar_delay = ar_delay - 1;
      end
    end
    // A beat once offered stays until taken
    if (!r_hold) begin
      rvalid = 1'b0;
      rlast  = 1'b0;
      if (burst_live && ($unsigned($random(seed)) % 3) != 0) begin
        rvalid = 1'b1;
        r_hold = 1'b1;
        rdata  = mem_word({burst_addr[31:3], beat_high, 2'b00});
        rresp  = err_line(burst_addr) ? SLVERR : OKAY;
        rlast  = beat_high;
      end
    end
  endtask

  // Models every handshake of the coming edge from values sampled between edges
  task automatic process_cycle();
    logic expect_hit;
    // Read data is taken exactly while a burst is in flight
    check_value("rready", 32'(rready), 32'(burst_live));
    if (held_prev) begin
      check_value("inst", inst, inst_prev);
      check_value("inst_pc", inst_pc, pc_prev);
      check_value("inst_error", 32'(inst_error), 32'(error_prev));
    end
    if (inst_valid && !held_prev) begin
      check_value("inst_pc", inst_pc, exp_pc);
      if (clean) begin
        // The lookup happened against last cycle's cache contents
        expect_hit = last_hit(inst_pc);
        check_value("ar transfer count", ar_count, expect_hit ? 0 : 1);
        if (!expect_hit) begin
          check_value("araddr", ar_last, {inst_pc[31:3], 3'b000});
        end
      end
    end
    last_valid = shadow_valid;
    last_tag   = shadow_tag;
    if (arvalid) begin
      check_value("araddr[2:0]", 32'(araddr[2:0]), 32'd0);
      if (ar_wait_prev) begin
        check_value("araddr", araddr, araddr_prev);
      end
      if (arready) begin
        ar_count   = ar_count + 1;
        ar_last    = araddr;
        burst_live = 1'b1;
        burst_addr = araddr;
        beat_high  = 1'b0;
        ar_delay   = -1;
      end
    end else if (ar_wait_prev) begin
      $display("arvalid dropped at %0t before the address was accepted", $time);
      stop_on_error();
    end
    if (rvalid && rready) begin
      r_hold = 1'b0;
      if (rlast) begin
        burst_live = 1'b0;
        // Clean cacheable lines are kept unless a flush lands on the same edge
        if (cacheable(burst_addr) && !err_line(burst_addr) && !flush) begin
          shadow_valid[burst_addr[6:3]] = 1'b1;
          shadow_tag[burst_addr[6:3]]   = burst_addr[31:TAG_LO];
        end
      end else begin
        beat_high = 1'b1;
      end
    end
    if (flush) begin
      shadow_valid = '0;
    end
    if (inst_valid && inst_ready) begin
      check_value("inst_pc", inst_pc, exp_pc);
      check_value("inst", inst, mem_word(inst_pc));
      check_value("inst_error", 32'(inst_error), 32'(err_line(inst_pc)));
      accepted    = accepted + 1;
      exp_pc      = exp_pc + 32'd4;
      ar_count    = 0;
      clean       = 1'b1;
      idle_cycles = 0;
    end
    if (redirect) begin
      exp_pc = redirect_pc;
      clean  = 1'b0;
    end
    held_prev    = inst_valid && !inst_ready;
    inst_prev    = inst;
    pc_prev      = inst_pc;
    error_prev   = inst_error;
    ar_wait_prev = arvalid && !arready;
    araddr_prev  = araddr;
  endtask

  initial begin
    seed         = 32'h8c01_1ca8;
    reset        = 1'b1;
    redirect     = 1'b0;
    redirect_pc  = `RESET_PC;
    flush        = 1'b0;
    inst_ready   = 1'b0;
    arready      = 1'b0;
    rdata        = 32'd0;
    rresp        = OKAY;
    rvalid       = 1'b0;
    rlast        = 1'b0;
    exp_pc       = `RESET_PC;
    shadow_valid = '0;
    last_valid   = '0;
    for (int i = 0; i < `LINE_COUNT; i++) begin
      shadow_tag[i] = '0;
      last_tag[i]   = '0;
    end
    ar_count     = 0;
    ar_last      = 32'd0;
    clean        = 1'b1;
    accepted     = 0;
    cycle        = 0;
    idle_cycles  = 0;
    stall_left   = 0;
    burst_live   = 1'b0;
    burst_addr   = 32'd0;
    beat_high    = 1'b0;
    ar_delay     = -1;
    r_hold       = 1'b0;
    held_prev    = 1'b0;
    inst_prev    = 32'd0;
    pc_prev      = 32'd0;
    error_prev   = 1'b0;
    ar_wait_prev = 1'b0;
    araddr_prev  = 32'd0;

    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;

    while (accepted < TARGET_COUNT) begin
      drive_inputs();
      @(negedge clock);
      process_cycle();
      @(posedge clock);
      #1;
      cycle       = cycle + 1;
      idle_cycles = idle_cycles + 1;
      if (idle_cycles > IDLE_LIMIT) begin
        $display("timeout at %0t: no instruction accepted for %0d cycles", $time, IDLE_LIMIT);
        stop_on_error();
      end
      if (cycle > MAX_CYCLES) begin
        $display("timeout at %0t: run exceeded %0d cycles", $time, MAX_CYCLES);
        stop_on_error();
      end
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/fetch_pkg.sv
hw/mem_pkg.sv
hw/refill_if.sv
hw/icache_array.sv
hw/refill_engine.sv
hw/fetch_control.sv
hw/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

// File: hw/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_control import fetch_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         redirect,
  input  logic [31:0]  redirect_pc,
  input  logic         inst_ready,
  output logic         inst_valid,
  output logic [31:0]  inst,
  output logic [31:0]  inst_pc,
  output logic         inst_error,
  input  logic         hit,
  input  logic [31:0]  hit_word,
  output logic [31:0]  lookup_pc,
  refill_if.controller req
);

  fetch_state_t state;

  logic [31:0] pc;
  logic [31:0] req_pc;
  logic        start_q;
  logic        stale;

  logic        slot_free;
  logic        lookup_go;
  logic        take_hit;
  logic        start_miss;
  logic        take_refill;
  logic [31:0] refill_word;

  assign lookup_pc = pc;

  // Refill request follows the latched miss address
  assign req.start     = start_q;
  assign req.line_addr = {req_pc[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
  assign req.cacheable = (req_pc[31:24] != `UNCACHED_TOP);

  // Output slot is free when empty or being taken this cycle
  assign slot_free   = !inst_valid || inst_ready;
  assign lookup_go   = (state == LOOKUP) && !redirect && slot_free;
  assign take_hit    = lookup_go && hit;
  assign start_miss  = lookup_go && !hit;
  assign take_refill = (state == WAIT_REFILL) && req.done && !stale && !redirect;

  assign refill_word = req_pc[2] ? req.line_data[63:32] : req.line_data[31:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= LOOKUP;
      pc         <= `RESET_PC;
      start_q    <= 1'b0;
      stale      <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      start_q <= start_miss;

      // Redirect overrides everything else
      if (redirect) begin
        pc <= redirect_pc;
      end else if (take_hit) begin
        pc <= pc + 32'd4;
      end else if (take_refill) begin
        pc <= req_pc + 32'd4;
      end

      if (redirect) begin
        inst_valid <= 1'b0;
      end else if (take_hit || take_refill) begin
        inst_valid <= 1'b1;
      end else if (inst_ready) begin
        inst_valid <= 1'b0;
      end

      case (state)
        LOOKUP: begin
          if (start_miss) begin
            state <= WAIT_REFILL;
          end
        end
        WAIT_REFILL: begin
          // burst always runs to the end, a stale result is simply dropped
          if (req.done) begin
            state <= LOOKUP;
            stale <= 1'b0;
          end else if (redirect) begin
            stale <= 1'b1;
          end
        end
        default: state <= LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take_hit) begin
      inst       <= hit_word;
      inst_pc    <= pc;
      inst_error <= 1'b0;
    end else if (take_refill) begin
      inst       <= refill_word;
      inst_pc    <= req_pc;
      inst_error <= req.error;
    end

    if (start_miss) begin
      req_pc <= pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Cache geometry, 16 lines of two 32-bit words
`define OFFSET_BITS 3
`define INDEX_BITS 4
`define TAG_BITS (32 - `OFFSET_BITS - `INDEX_BITS)
`define LINE_COUNT 16

// Fetch starts here after reset
`define RESET_PC 32'h3000_0000

// Top address byte of the region that is never cached
`define UNCACHED_TOP 8'h0f

// Two beats of 32 bits fill one line
`define BURST_BEATS 2

`endif

// File: hw/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // Controller either looks up the cache or waits on the refill engine
  typedef enum logic {
    LOOKUP      = 1'b0,
    WAIT_REFILL = 1'b1
  } fetch_state_t;

  // One cache entry, 90 bits
  typedef struct packed {
    logic                        valid;
    logic [`TAG_BITS-1:0]        tag;
    logic [`BURST_BEATS*32-1:0]  data;
  } cache_line_t;

endpackage

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import mem_pkg::*; (
  input  logic         clock,
  input  logic         reset,

  input  logic         redirect,
  input  logic [31:0]  redirect_pc,
  input  logic         flush,

  output logic         inst_valid,
  output logic [31:0]  inst,
  output logic [31:0]  inst_pc,
  output logic         inst_error,
  input  logic         inst_ready,

  output logic [31:0]  araddr,
  output logic         arvalid,
  input  logic         arready,
  input  logic [31:0]  rdata,
  input  resp_t        rresp,
  input  logic         rvalid,
  input  logic         rlast,
  output logic         rready
);

  logic        hit;
  logic [31:0] hit_word;
  logic [31:0] lookup_pc;

  refill_if u_refill_if ();

  icache_array u_icache_array (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (lookup_pc),
    .flush     (flush),
    .fill      (u_refill_if.cache),
    .hit       (hit),
    .hit_word  (hit_word)
  );

  refill_engine u_refill_engine (
    .clock   (clock),
    .reset   (reset),
    .req     (u_refill_if.engine),
    .araddr  (araddr),
    .arvalid (arvalid),
    .rready  (rready),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rlast   (rlast)
  );

  fetch_control u_fetch_control (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst_ready  (inst_ready),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_error  (inst_error),
    .hit         (hit),
    .hit_word    (hit_word),
    .lookup_pc   (lookup_pc),
    .req         (u_refill_if.controller)
  );

endmodule

`default_nettype wire

// File: hw/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module icache_array import fetch_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [31:0]       lookup_pc,
  input  logic              flush,
  refill_if.cache           fill,
  output logic              hit,
  output logic [31:0]       hit_word
);

  localparam int INDEX_LO = `OFFSET_BITS;
  localparam int INDEX_HI = `OFFSET_BITS + `INDEX_BITS - 1;
  localparam int TAG_LO   = `OFFSET_BITS + `INDEX_BITS;

  cache_line_t lines [`LINE_COUNT];

  logic [`INDEX_BITS-1:0] lookup_index;
  logic [`INDEX_BITS-1:0] fill_index;
  logic                   fill_write;
  cache_line_t            entry;

  assign lookup_index = lookup_pc[INDEX_HI:INDEX_LO];
  assign fill_index   = fill.line_addr[INDEX_HI:INDEX_LO];
  assign entry        = lines[lookup_index];

  // Only clean, cacheable refills are kept
  assign fill_write = fill.done && fill.cacheable && !fill.error;

  assign hit = entry.valid
            && (entry.tag == lookup_pc[31:TAG_LO])
            && (lookup_pc[31:24] != `UNCACHED_TOP);

  assign hit_word = lookup_pc[2] ? entry.data[63:32] : entry.data[31:0];

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      // flush wins over a fill landing in the same cycle
      for (int i = 0; i < `LINE_COUNT; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (fill_write) begin
      lines[fill_index].valid <= 1'b1;
      lines[fill_index].tag   <= fill.line_addr[31:TAG_LO];
      lines[fill_index].data  <= fill.line_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Read response codes of the memory bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // Refill engine states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ADDR = 2'b01,
    DATA = 2'b10
  } refill_state_t;

endpackage

`default_nettype wire

// File: hw/refill_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module refill_engine import mem_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  refill_if.engine     req,
  output logic [31:0]  araddr,
  output logic         arvalid,
  output logic         rready,
  input  logic         arready,
  input  logic [31:0]  rdata,
  input  resp_t        rresp,
  input  logic         rvalid,
  input  logic         rlast
);

  refill_state_t state;

  logic [31:0] addr_q;
  logic [31:0] low_word;
  logic        error_acc;
  logic        beat_ok;
  logic        beat_take;

  assign araddr  = addr_q;
  assign arvalid = (state == ADDR);
  assign rready  = (state == DATA);

  assign beat_take = rready && rvalid;
  assign beat_ok   = (rresp == OKAY);

  // Completion is flagged during the rlast beat itself, so the
  // controller can register the word at the same edge
  assign req.done      = beat_take && rlast;
  assign req.line_data = {rdata, low_word};
  assign req.error     = error_acc || !beat_ok;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (req.start) begin
            state <= ADDR;
          end
        end
        ADDR: begin
          if (arready) begin
            state <= DATA;
          end
        end
        DATA: begin
          if (beat_take && rlast) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && req.start) begin
      addr_q    <= {req.line_addr[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
      error_acc <= 1'b0;
    end else if (beat_take && !rlast) begin
      // first beat is the low word of the line
      low_word  <= rdata;
      error_acc <= error_acc || !beat_ok;
    end
  end

endmodule

`default_nettype wire

// File: hw/refill_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

interface refill_if;

  logic                        start;
  logic [31:0]                 line_addr;
  logic                        done;
  logic [`BURST_BEATS*32-1:0]  line_data;
  logic                        error;
  logic                        cacheable;

  modport controller (
    output start, line_addr, cacheable,
    input  done, line_data, error
  );

  modport engine (
    input  start, line_addr, cacheable,
    output done, line_data, error
  );

  // Cache snoops the completed refill to fill the line
  modport cache (
    input done, line_addr, line_data, error, cacheable
  );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile the fetch stage with its testbench and run it under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fetch_tb -f flist.f -o fetch_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/fetch_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
